// ==== csr_pkg.sv ====
// csr unit shared definitions

package csr_pkg;

    //**********************************************************************
    // widths
    //**********************************************************************

    // register width, rv32 only
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;

    // [11:10] access bits, 2'b11 is read-only
    // [9:8] lowest privilege that may touch the address
    typedef logic [11:0] csr_addr_t;

    typedef logic [1:0] priv_t;

    // instructions retired in one cycle, 0 to 2
    typedef logic [1:0] inst_inc_t;

    localparam priv_t PRIV_USER       = 2'd0;
    localparam priv_t PRIV_SUPERVISOR = 2'd1;
    localparam priv_t PRIV_MACHINE    = 2'd3;

    // op 0 is treated as read-write
    typedef enum logic [1:0] {
        CSR_RW = 2'd1,
        CSR_RS = 2'd2,
        CSR_RC = 2'd3
    } csr_op_t;

    // one select per kept register, counters split by half
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_MISA,
        SEL_MHARTID,
        SEL_MTVEC,
        SEL_MSCRATCH,
        SEL_MEPC,
        SEL_MCYCLE_LO,
        SEL_MCYCLE_HI,
        SEL_MINSTRET_LO,
        SEL_MINSTRET_HI
    } csr_sel_t;

    //**********************************************************************
    // addresses
    //**********************************************************************

    // machine info and trap setup
    localparam csr_addr_t ADDR_MISA      = 12'h301;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;

    // machine counters
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;

    // user shadows of the same counters
    localparam csr_addr_t ADDR_CYCLE     = 12'hC00;
    localparam csr_addr_t ADDR_INSTRET   = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH    = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH  = 12'hC82;

    // base rv32 in [31:30], then U (20), S (18), M (12), I (8)
    localparam xlen_t MISA_VALUE = 32'h4014_1100;

endpackage

// ==== csr_regs.sv ====
// csr register file and counters

`timescale 1ns/1ps

module csr_regs #(
    parameter int             TIMER_W   = 64,
    parameter csr_pkg::xlen_t HART_ID   = 32'h0000_0000,
    parameter csr_pkg::xlen_t RESET_VEC = 32'h8000_0000
) (
    input  logic           clk,
    input  logic           rst,
    csr_req_if.sink        req,
    input  logic           instruction_complete,
    input  logic           instruction_issued_no_rd,
    output logic           result_valid,
    output csr_pkg::xlen_t result_data,
    output logic           result_fault
);
    import csr_pkg::*;

    // writable machine registers
    xlen_t              mtvec;
    xlen_t              mscratch;
    xlen_t              mepc;

    // free-running counters, read by halves
    logic [TIMER_W-1:0] mcycle;
    logic [TIMER_W-1:0] minstret;
    // retire count from the previous edge
    inst_inc_t          inst_inc;

    xlen_t              old_value;
    xlen_t              new_value;
    logic               do_write;

    //**********************************************************************
    // read mux
    //**********************************************************************

    always_comb begin
        case (req.sel)
            SEL_MISA:        old_value = MISA_VALUE;
            SEL_MHARTID:     old_value = HART_ID;
            SEL_MTVEC:       old_value = mtvec;
            SEL_MSCRATCH:    old_value = mscratch;
            SEL_MEPC:        old_value = mepc;
            SEL_MCYCLE_LO:   old_value = mcycle[XLEN-1:0];
            SEL_MCYCLE_HI:   old_value = xlen_t'(mcycle[TIMER_W-1:XLEN]);
            SEL_MINSTRET_LO: old_value = minstret[XLEN-1:0];
            SEL_MINSTRET_HI: old_value = xlen_t'(minstret[TIMER_W-1:XLEN]);
            // unknown or faulting access
            default:         old_value = '0;
        endcase
    end

    //**********************************************************************
    // read-modify-write
    //**********************************************************************

    always_comb begin
        case (req.op)
            CSR_RS:  new_value = old_value | req.wdata;
            CSR_RC:  new_value = old_value & ~req.wdata;
            // rw and op 0
            default: new_value = req.wdata;
        endcase
    end

    assign do_write = req.valid && req.write;

    // old value goes back in the request cycle
    assign result_valid = req.valid;
    assign result_data  = old_value;
    assign result_fault = req.fault;

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec    <= RESET_VEC;
            mscratch <= '0;
            mepc     <= '0;
        end else if (do_write) begin
            case (req.sel)
                // vector and pc stay word aligned
                SEL_MTVEC:    mtvec    <= {new_value[XLEN-1:2], 2'b00};
                SEL_MSCRATCH: mscratch <= new_value;
                SEL_MEPC:     mepc     <= {new_value[XLEN-1:2], 2'b00};
                default:      ;
            endcase
        end
    end

    //**********************************************************************
    // counters
    //**********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
            inst_inc <= '0;
        end else begin
            mcycle   <= mcycle + 1'b1;
            // retire count lands one edge late
            minstret <= minstret + inst_inc;
            inst_inc <= {1'b0, instruction_complete} + {1'b0, instruction_issued_no_rd};
        end
    end

    // high half needs at least one bit
    assert property (@(posedge clk) TIMER_W > XLEN);

endmodule

// ==== csr_req_if.sv ====
// decoded csr request link

`timescale 1ns/1ps

interface csr_req_if;
    import csr_pkg::*;

    // one-cycle strobe per request
    logic     valid;
    csr_sel_t sel;
    csr_op_t  op;
    xlen_t    wdata;
    // update allowed for this address and privilege
    logic     write;
    // unknown address or privilege too low
    logic     fault;

    // decoder side
    modport source (
        output valid, sel, op, wdata, write, fault
    );

    // register file side
    modport sink (
        input valid, sel, op, wdata, write, fault
    );

endinterface

// ==== csr_request.sv ====
// csr request decoder

`timescale 1ns/1ps

module csr_request (
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::xlen_t     rs1,
    input  csr_pkg::priv_t     privilege,
    input  logic               new_request,
    csr_req_if.source          req
);
    import csr_pkg::*;

    csr_sel_t addr_sel;
    logic     known_addr;
    logic     writable_addr;
    logic     read_only;
    logic     priv_low;
    logic     fault;

    //**********************************************************************
    // address lookup
    //**********************************************************************

    always_comb begin
        addr_sel      = SEL_NONE;
        writable_addr = 1'b0;
        case (csr_addr)
            ADDR_MISA:      addr_sel = SEL_MISA;
            ADDR_MHARTID:   addr_sel = SEL_MHARTID;
            ADDR_MTVEC: begin
                addr_sel      = SEL_MTVEC;
                writable_addr = 1'b1;
            end
            ADDR_MSCRATCH: begin
                addr_sel      = SEL_MSCRATCH;
                writable_addr = 1'b1;
            end
            ADDR_MEPC: begin
                addr_sel      = SEL_MEPC;
                writable_addr = 1'b1;
            end
            // counters, machine and user views alike, never written
            ADDR_MCYCLE,    ADDR_CYCLE:    addr_sel = SEL_MCYCLE_LO;
            ADDR_MCYCLEH,   ADDR_CYCLEH:   addr_sel = SEL_MCYCLE_HI;
            ADDR_MINSTRET,  ADDR_INSTRET:  addr_sel = SEL_MINSTRET_LO;
            ADDR_MINSTRETH, ADDR_INSTRETH: addr_sel = SEL_MINSTRET_HI;
            default:        addr_sel = SEL_NONE;
        endcase
    end

    assign known_addr = (addr_sel != SEL_NONE);

    // access bits 2'b11 mark a read-only address
    assign read_only  = (csr_addr[11:10] == 2'b11);

    // address needs a higher level than the hart runs at
    assign priv_low   = (csr_addr[9:8] > privilege);

    assign fault      = !known_addr || priv_low;

    //**********************************************************************
    // request out
    //**********************************************************************

    assign req.valid = new_request;
    // faulting access reads back as zero
    assign req.sel   = fault ? SEL_NONE : addr_sel;
    assign req.op    = csr_op;
    assign req.wdata = rs1;
    assign req.write = writable_addr && !read_only && !fault;
    assign req.fault = fault;

endmodule

// ==== csr_unit.sv ====
// csr unit top level

`timescale 1ns/1ps

module csr_unit #(
    parameter int             TIMER_W   = 64,
    parameter csr_pkg::xlen_t HART_ID   = 32'h0000_0000,
    parameter csr_pkg::xlen_t RESET_VEC = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               new_request,
    input  csr_pkg::csr_addr_t csr_addr,
    input  csr_pkg::csr_op_t   csr_op,
    input  csr_pkg::xlen_t     rs1,
    input  csr_pkg::priv_t     privilege,
    input  logic               instruction_complete,
    input  logic               instruction_issued_no_rd,
    input  logic               accepted,
    output logic               ready,
    output logic               done,
    output csr_pkg::xlen_t     rd,
    output logic               illegal_instruction
);
    import csr_pkg::*;

    // result path from register file to holding stage
    logic  result_valid;
    xlen_t result_data;
    logic  result_fault;

    csr_req_if req_if ();

    //**********************************************************************
    // stages
    //**********************************************************************

    csr_request csr_request_inst (
        .csr_addr    (csr_addr),
        .csr_op      (csr_op),
        .rs1         (rs1),
        .privilege   (privilege),
        .new_request (new_request),
        .req         (req_if.source)
    );

    csr_regs #(
        .TIMER_W   (TIMER_W),
        .HART_ID   (HART_ID),
        .RESET_VEC (RESET_VEC)
    ) csr_regs_inst (
        .clk                      (clk),
        .rst                      (rst),
        .req                      (req_if.sink),
        .instruction_complete     (instruction_complete),
        .instruction_issued_no_rd (instruction_issued_no_rd),
        .result_valid             (result_valid),
        .result_data              (result_data),
        .result_fault             (result_fault)
    );

    csr_writeback csr_writeback_inst (
        .clk                 (clk),
        .rst                 (rst),
        .result_valid        (result_valid),
        .result_data         (result_data),
        .result_fault        (result_fault),
        .accepted            (accepted),
        .ready               (ready),
        .done                (done),
        .rd                  (rd),
        .illegal_instruction (illegal_instruction)
    );

    // pipeline may only issue while the unit is free
    assert property (@(posedge clk) disable iff (rst)
        new_request |-> ready);

endmodule

// ==== csr_writeback.sv ====
// csr result holding stage

`timescale 1ns/1ps

module csr_writeback (
    input  logic           clk,
    input  logic           rst,
    input  logic           result_valid,
    input  csr_pkg::xlen_t result_data,
    input  logic           result_fault,
    input  logic           accepted,
    output logic           ready,
    output logic           done,
    output csr_pkg::xlen_t rd,
    output logic           illegal_instruction
);
    import csr_pkg::*;

    // result payload, held while done is up
    always_ff @(posedge clk) begin
        if (result_valid) begin
            rd                  <= result_data;
            illegal_instruction <= result_fault;
        end
    end

    // done rises after the request, drops once the pipeline takes it
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (result_valid) begin
            done <= 1'b1;
        end else if (done && accepted) begin
            done <= 1'b0;
        end
    end

    // one item in flight, ready returns with acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            ready <= 1'b1;
        end else if (result_valid) begin
            ready <= 1'b0;
        end else if (done && accepted) begin
            ready <= 1'b1;
        end
    end

    // no second result while the first one is still unclaimed
    assert property (@(posedge clk) disable iff (rst)
        result_valid |-> !(done && !accepted));

    // unclaimed result holds through the next edge
    assert property (@(posedge clk) disable iff (rst)
        (done && !accepted) |=> done && $stable(rd) && $stable(illegal_instruction));

endmodule

// ==== tb.f ====
csr_pkg.sv
csr_req_if.sv
csr_request.sv
csr_regs.sv
csr_writeback.sv
csr_unit.sv
tb_csr_unit.sv

// ==== tb_csr_unit.sv ====
// csr unit testbench

`timescale 1ns/1ps

module tb_csr_unit;
    import csr_pkg::*;

    // source of a row's expected rd
    typedef enum logic [1:0] {
        KIND_EXACT,
        KIND_CYCLE,
        KIND_RETIRE
    } kind_t;

    typedef struct {
        csr_addr_t addr;
        csr_op_t   op;
        xlen_t     rs1;
        priv_t     priv;
        kind_t     kind;
        xlen_t     exp_rd;
        logic      exp_illegal;
    } row_t;

    // rv32 base in the top bits, with U, S, M and I
    localparam xlen_t EXP_MISA = 32'h4000_0000 | (32'd1 << 20) | (32'd1 << 18)
                               | (32'd1 << 12) | (32'd1 << 8);

    logic      clk;
    logic      rst;
    logic      new_request;
    csr_addr_t csr_addr;
    csr_op_t   csr_op;
    xlen_t     rs1;
    priv_t     privilege;
    logic      instruction_complete;
    logic      instruction_issued_no_rd;
    logic      accepted;
    logic      ready;
    logic      done;
    xlen_t     rd;
    logic      illegal_instruction;

    row_t        rows[$];
    // reference counters
    logic [63:0] edge_count;
    logic [63:0] retire_sum;
    int unsigned cycle_total;
    int unsigned cycle_limit;

    csr_unit csr_unit_inst (
        .clk                      (clk),
        .rst                      (rst),
        .new_request              (new_request),
        .csr_addr                 (csr_addr),
        .csr_op                   (csr_op),
        .rs1                      (rs1),
        .privilege                (privilege),
        .instruction_complete     (instruction_complete),
        .instruction_issued_no_rd (instruction_issued_no_rd),
        .accepted                 (accepted),
        .ready                    (ready),
        .done                     (done),
        .rd                       (rd),
        .illegal_instruction      (illegal_instruction)
    );

    //**********************************************************************
    // clock, cycle reference, timeout
    //**********************************************************************

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // mcycle rule, one count per edge out of reset
    always @(posedge clk) begin
        if (rst) begin
            edge_count <= 64'd0;
        end else begin
            edge_count <= edge_count + 64'd1;
        end
    end

    always @(posedge clk) begin
        cycle_total <= cycle_total + 1;
        if (cycle_total >= cycle_limit) begin
            $display("the run timed out after %0d cycles", cycle_limit);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    //**********************************************************************
    // compare tasks
    //**********************************************************************

    task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
            $display("tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    //**********************************************************************
    // stimulus table
    //**********************************************************************

    task automatic add_row(input csr_addr_t addr, input csr_op_t op, input xlen_t rs1_v,
                           input priv_t priv, input kind_t kind, input xlen_t exp_rd,
                           input logic exp_illegal);
        row_t r;
        r = '{addr, op, rs1_v, priv, kind, exp_rd, exp_illegal};
        rows.push_back(r);
    endtask

    task automatic fill_table();
        // read-only info and reset value of mtvec
        add_row(ADDR_MISA,     CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, EXP_MISA, 1'b0);
        add_row(ADDR_MHARTID,  CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
        add_row(ADDR_MTVEC,    CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'h8000_0000, 1'b0);
        // mscratch rw, rs, rc chain, old value back each time
        add_row(ADDR_MSCRATCH, CSR_RW, 32'hA5A5_F00F, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
        add_row(ADDR_MSCRATCH, CSR_RS, 32'h0F0, PRIV_MACHINE, KIND_EXACT, 32'hA5A5_F00F, 1'b0);
        add_row(ADDR_MSCRATCH, CSR_RC, 32'h00F, PRIV_MACHINE, KIND_EXACT, 32'hA5A5_F0FF, 1'b0);
        add_row(ADDR_MSCRATCH, CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'hA5A5_F0F0, 1'b0);
        // mepc drops its low two bits
        add_row(ADDR_MEPC,     CSR_RW, 32'h1237, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
        add_row(ADDR_MEPC,     CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'h1234, 1'b0);
        // illegal accesses, then mscratch unchanged
        add_row(ADDR_MSCRATCH, CSR_RW, 32'hDEAD, PRIV_USER, KIND_EXACT, 32'h0, 1'b1);
        add_row(12'h7C0,       CSR_RW, 32'hFFFF, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b1);
        add_row(ADDR_MSCRATCH, CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'hA5A5_F0F0, 1'b0);
        // mhartid write has no effect
        add_row(ADDR_MHARTID,  CSR_RW, 32'h55, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
        add_row(ADDR_MHARTID,  CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
        // cycle counter, both views, high halves still zero
        add_row(ADDR_MCYCLE,   CSR_RS, 32'h0, PRIV_MACHINE, KIND_CYCLE, 32'h0, 1'b0);
        add_row(ADDR_MCYCLEH,  CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
        add_row(ADDR_CYCLEH,   CSR_RS, 32'h0, PRIV_USER, KIND_EXACT, 32'h0, 1'b0);
        add_row(ADDR_CYCLE,    CSR_RS, 32'h0, PRIV_USER, KIND_CYCLE, 32'h0, 1'b0);
        // counter writes ignored
        add_row(ADDR_MCYCLE,   CSR_RW, 32'h0, PRIV_MACHINE, KIND_CYCLE, 32'h0, 1'b0);
        add_row(ADDR_MCYCLE,   CSR_RS, 32'h0, PRIV_MACHINE, KIND_CYCLE, 32'h0, 1'b0);
        // retire counter after random pulses
        add_row(ADDR_MINSTRET, CSR_RS, 32'h0, PRIV_MACHINE, KIND_RETIRE, 32'h0, 1'b0);
        add_row(ADDR_INSTRET,  CSR_RS, 32'h0, PRIV_USER, KIND_RETIRE, 32'h0, 1'b0);
        add_row(ADDR_MINSTRETH, CSR_RS, 32'h0, PRIV_MACHINE, KIND_EXACT, 32'h0, 1'b0);
    endtask

    //**********************************************************************
    // row driver
    //**********************************************************************

    // random retire pulses, then idle so minstret settles
    task automatic retire_burst();
        int   n;
        logic ic;
        logic inr;
        n = 4 + ($urandom % 8);
        repeat (n) begin
            @(negedge clk);
            ic  = $urandom % 2;
            inr = $urandom % 2;
            instruction_complete     = ic;
            instruction_issued_no_rd = inr;
            retire_sum = retire_sum + ic + inr;
        end
        @(negedge clk);
        instruction_complete     = 1'b0;
        instruction_issued_no_rd = 1'b0;
        repeat (3) @(negedge clk);
    endtask

    task automatic run_row(input row_t r);
        xlen_t exp_rd;
        xlen_t held_rd;
        logic  held_illegal;
        int    wait_cycles;
        int    delay;
        if (r.kind == KIND_RETIRE) begin
            retire_burst();
        end
        @(negedge clk);
        check_flag("ready", ready, 1'b1);
        // counters read their value from before the request edge
        case (r.kind)
            KIND_CYCLE:  exp_rd = edge_count[31:0];
            KIND_RETIRE: exp_rd = retire_sum[31:0];
            default:     exp_rd = r.exp_rd;
        endcase
        new_request = 1'b1;
        csr_addr    = r.addr;
        csr_op      = r.op;
        rs1         = r.rs1;
        privilege   = r.priv;
        @(negedge clk);
        new_request = 1'b0;
        wait_cycles = 0;
        while (!done && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (!done) begin
            $display("done never came for the request to address %h", r.addr);
            $display("tests failed");
            $fatal(1, "no done");
        end
        check_data("rd", rd, exp_rd);
        check_flag("illegal_instruction", illegal_instruction, r.exp_illegal);
        held_rd      = rd;
        held_illegal = illegal_instruction;
        // back-pressure, result must hold
        delay = $urandom % 4;
        repeat (delay) begin
            @(negedge clk);
            check_flag("done", done, 1'b1);
            check_flag("ready", ready, 1'b0);
            check_data("rd", rd, held_rd);
            check_flag("illegal_instruction", illegal_instruction, held_illegal);
        end
        accepted = 1'b1;
        @(negedge clk);
        accepted = 1'b0;
        check_flag("done", done, 1'b0);
        check_flag("ready", ready, 1'b1);
    endtask

    //**********************************************************************
    // main sequence
    //**********************************************************************

    initial begin
        void'($urandom(94826));
        rst                      = 1'b1;
        new_request              = 1'b0;
        csr_addr                 = '0;
        csr_op                   = CSR_RW;
        rs1                      = '0;
        privilege                = PRIV_MACHINE;
        instruction_complete     = 1'b0;
        instruction_issued_no_rd = 1'b0;
        accepted                 = 1'b0;
        retire_sum               = 64'd0;
        cycle_total              = 0;
        fill_table();
        cycle_limit = 40 * rows.size() + 200;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("done", done, 1'b0);
        check_flag("ready", ready, 1'b1);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (2) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule
